// File: list.f
+incdir+tests
design/tageGeomPkg.sv
design/tageTypesPkg.sv
design/foldHash.sv
design/tableIndexer.sv
design/predTable.sv
design/usefulTable.sv
design/predictSelect.sv
design/tagePredictor.sv
tests/tageTb.sv

// File: tests/tageModel.svh
`ifndef TAGE_MODEL_SVH
`define TAGE_MODEL_SVH

logic baseValid [1 << baseIdxWidth];
ctr_t baseCtr [1 << baseIdxWidth];
logic tagValid [numTagged][1 << maxIdxWidth];
logic [maxTagWidth-1:0] tagTag [numTagged][1 << maxIdxWidth];
ctr_t tagCtr [numTagged][1 << maxIdxWidth];
ctr_t tagUseful [numTagged][1 << maxIdxWidth];
hist_t modelHist;

// bit b of the input lands on bit b mod w
function automatic logic [7:0] foldBits(logic [31:0] x, int len, int w);
    logic [7:0] r;
    r = '0;
    for (int b = 0; b < len; b++) begin
        r[b % w] ^= x[b];
    end
    return r;
endfunction

function automatic logic [31:0] newestBits(int i, hist_t h);
    return 32'(h >> (histWidth - histLen[i]));
endfunction

function automatic int unsigned taggedIndex(int i, pc_t pc, hist_t h);
    int unsigned pcBits;
    pcBits = (pc >> pcIdxLsb) & ((1 << tagIdxWidth[i]) - 1);
    return pcBits ^ foldBits(newestBits(i, h), histLen[i], tagIdxWidth[i]);
endfunction

function automatic logic [7:0] taggedTag(int i, pc_t pc, hist_t h);
    return foldBits(pc >> pcTagLsb, pcWidth - pcTagLsb, tagWidth[i])
        ^ foldBits(newestBits(i, h), histLen[i], tagWidth[i]);
endfunction

function automatic void modelReset();
    modelHist = '0;
    baseValid = '{default: 1'b0};
    tagValid = '{default: '0};
    tagUseful = '{default: '0};
endfunction

function automatic void modelUpdate(update_t u);
    int unsigned bi;
    int unsigned idx;
    int t;
    bi = (u.pc >> pcIdxLsb) & ((1 << baseIdxWidth) - 1);
    t = int'(u.tableNum) - 1;
    if (u.tableNum == 0) begin
        baseValid[bi] = 1'b1;
        baseCtr[bi] = u.ctr;
    end else begin
        idx = taggedIndex(t, u.pc, u.hist);
        tagValid[t][idx] = 1'b1;
        tagTag[t][idx] = taggedTag(t, u.pc, u.hist);
        tagCtr[t][idx] = u.ctr;
        tagUseful[t][idx] = u.useful;
    end
endfunction

// longest hitting history wins
function automatic prediction_t refPredict(pc_t pc, hist_t h);
    prediction_t p;
    int unsigned bi;
    int unsigned idx;
    bi = (pc >> pcIdxLsb) & ((1 << baseIdxWidth) - 1);
    p.provider = providerWidth'(providerBase);
    p.ctr = baseValid[bi] ? baseCtr[bi] : ctr_t'(baseInitCtr);
    for (int i = 0; i < numTagged; i++) begin
        idx = taggedIndex(i, pc, h);
        p.useful[i] = tagUseful[i][idx];
        if (tagValid[i][idx] && tagTag[i][idx] == taggedTag(i, pc, h)) begin
            p.provider = providerWidth'(i + 1);
            p.ctr = tagCtr[i][idx];
        end
    end
    p.taken = p.ctr > takenThreshold;
    return p;
endfunction

`endif

// File: tests/tageTb.sv
module tageTb;

    import tageGeomPkg::*;
    import tageTypesPkg::*;

    `include "tageModel.svh"

    typedef struct packed {
        prediction_t pred;
        int unsigned due;
    } pending_t;

    logic Clk = 1'b0;
    logic reset;
    logic lookupValid;
    pc_t lookupPc;
    logic specValid;
    logic specTaken;
    logic repairValid;
    hist_t repairHist;
    logic updValid;
    update_t upd;
    logic usefulClear;
    logic stall;
    logic flush;
    logic predValid;
    prediction_t pred;

    pending_t expQ [$];
    int unsigned edgeCount = 0;
    logic advanced = 1'b0;
    logic heldValid;
    prediction_t heldPred;
    int unsigned waitCount;
    pc_t groupPc [16];
    hist_t groupHist [16];

    tagePredictor UUT (
        .Clk(Clk), .reset(reset),
        .lookupValid(lookupValid), .lookupPc(lookupPc),
        .specValid(specValid), .specTaken(specTaken),
        .repairValid(repairValid), .repairHist(repairHist),
        .updValid(updValid), .upd(upd), .usefulClear(usefulClear),
        .stall(stall), .flush(flush),
        .predValid(predValid), .pred(pred)
    );

    always #10 Clk = ~Clk;

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic abortRun(string why);
        $display("t=%0t %s", $time, why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // model follows the DUT edge, then strobes drop
    task automatic advanceCycle();
        pending_t entry;
        if (lookupValid && !stall) begin
            entry.pred = refPredict(lookupPc, modelHist);
            entry.due = edgeCount + 2;
            expQ.push_back(entry);
        end
        if (!stall && updValid) begin
            modelUpdate(upd);
        end
        if (!stall && usefulClear) begin
            tagUseful = '{default: '0};
        end
        if (repairValid) begin
            modelHist = repairHist;
        end else if (specValid) begin
            modelHist = {specTaken, modelHist[histWidth-1:1]};
        end
        @(posedge Clk);
        #2;
        lookupValid = 1'b0;
        specValid = 1'b0;
        repairValid = 1'b0;
        updValid = 1'b0;
        usefulClear = 1'b0;
        flush = 1'b0;
    endtask

    task automatic idleCycles(int n);
        for (int c = 0; c < n; c++) begin
            advanceCycle();
        end
    endtask

    task automatic issueLookup(pc_t pc);
        lookupValid = 1'b1;
        lookupPc = pc;
        advanceCycle();
    endtask

    task automatic loadHistory(hist_t h);
        repairValid = 1'b1;
        repairHist = h;
        advanceCycle();
    endtask

    task automatic writeTable(int tableNum, pc_t pc, hist_t h, ctr_t ctr, ctr_t useful);
        updValid = 1'b1;
        upd = '{tableNum: providerWidth'(tableNum), pc: pc, hist: h, ctr: ctr, useful: useful};
        advanceCycle();
    endtask

    always @(posedge Clk) begin
        advanced = !stall;
        if (!stall) begin
            edgeCount++;
            // flush drops whatever sits in either stage
            if (flush) begin
                expQ.delete();
            end
        end
    end

    always @(negedge Clk) begin : compareProc
        pending_t front;
        if (!reset && advanced) begin
            if (expQ.size() > 0 && expQ[0].due == edgeCount) begin
                front = expQ.pop_front();
                checkValue("predValid", predValid, 1'b1);
                checkValue("pred.taken", pred.taken, front.pred.taken);
                checkValue("pred.ctr", pred.ctr, front.pred.ctr);
                checkValue("pred.provider", pred.provider, front.pred.provider);
                checkValue("pred.useful", pred.useful, front.pred.useful);
            end else begin
                checkValue("predValid", predValid, 1'b0);
            end
            heldValid = predValid;
            heldPred = pred;
        end else if (!reset) begin
            // outputs frozen under stall
            checkValue("predValid", predValid, heldValid);
            checkValue("pred", pred, heldPred);
        end
    end

    initial begin
        void'($urandom(41273));
        modelReset();
        reset = 1'b1;
        lookupValid = 1'b0;
        lookupPc = '0;
        specValid = 1'b0;
        specTaken = 1'b0;
        repairValid = 1'b0;
        repairHist = '0;
        updValid = 1'b0;
        upd = '0;
        usefulClear = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (10) @(posedge Clk);
        #2;
        reset = 1'b0;

        // empty tables report the base default
        for (int n = 0; n < 20; n++) begin
            issueLookup($urandom());
        end

        // random overlapping writes, then lookups at the same pc and history
        for (int g = 0; g < 16; g++) begin
            groupPc[g] = $urandom();
            groupHist[g] = hist_t'($urandom());
            loadHistory(groupHist[g]);
            for (int t = 0; t <= numTagged; t++) begin
                if (($urandom() % 3) != 0) begin
                    writeTable(t, groupPc[g], groupHist[g],
                               ctr_t'($urandom()), ctr_t'($urandom()));
                end
            end
            issueLookup(groupPc[g]);
            issueLookup($urandom());
        end

        // shifts move the history away, a repair brings it back
        for (int g = 0; g < 6; g++) begin
            loadHistory(groupHist[g]);
            specValid = 1'b1;
            specTaken = $urandom() % 2;
            advanceCycle();
            issueLookup(groupPc[g]);
            repairValid = 1'b1;
            repairHist = groupHist[g];
            specValid = 1'b1;
            lookupValid = 1'b1;
            lookupPc = groupPc[g];
            advanceCycle();
            issueLookup(groupPc[g]);
        end

        // clear wins over the useful value of a same-cycle update
        usefulClear = 1'b1;
        writeTable(1, groupPc[1], groupHist[1], 3'd6, 3'd7);
        for (int g = 0; g < 16; g++) begin
            loadHistory(groupHist[g]);
            issueLookup(groupPc[g]);
        end

        // stall with lookups in flight and a write that must be ignored
        loadHistory(groupHist[2]);
        issueLookup(groupPc[2]);
        issueLookup(groupPc[3]);
        stall = 1'b1;
        idleCycles(2);
        writeTable(4, groupPc[2], groupHist[2], 3'd7, 3'd5);
        idleCycles(1);
        stall = 1'b0;
        issueLookup(groupPc[2]);

        // flush drops the two youngest lookups
        issueLookup(groupPc[4]);
        issueLookup(groupPc[5]);
        flush = 1'b1;
        lookupValid = 1'b1;
        lookupPc = groupPc[6];
        advanceCycle();
        issueLookup(groupPc[7]);

        waitCount = 0;
        while (expQ.size() != 0 && waitCount < 10) begin
            idleCycles(1);
            waitCount++;
        end
        if (expQ.size() != 0) begin
            abortRun("timed out waiting for the remaining predictions");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: design/tagePredictor.sv
module tagePredictor (
    input logic Clk,
    input logic reset,
    input logic lookupValid,
    input tageTypesPkg::pc_t lookupPc,
    input logic specValid,
    input logic specTaken,
    input logic repairValid,
    input tageTypesPkg::hist_t repairHist,
    input logic updValid,
    input tageTypesPkg::update_t upd,
    input logic usefulClear,
    input logic stall,
    input logic flush,
    output logic predValid,
    output tageTypesPkg::prediction_t pred
);

    import tageGeomPkg::*;
    import tageTypesPkg::*;

    hist_t histReg;
    logic stage1Valid;
    logic [numTagged-1:0][maxTagWidth-1:0] lookupTagReg;
    tableAddr_t lookupAddr;
    tableAddr_t updAddr;
    logic readEn;
    logic clearEn;
    logic [numTagged:0] tableWe;
    baseEntry_t baseRd;
    logic baseHit;
    entry7_t t1Rd;
    entry7_t t2Rd;
    entry8_t t3Rd;
    entry8_t t4Rd;
    logic t1Hit;
    logic t2Hit;
    logic t3Hit;
    logic t4Hit;
    wire ctr_t [numTagged-1:0] usefulRd;

    // repair beats the speculative shift, stall does not matter here
    always_ff @(posedge Clk) begin
        if (reset) begin
            histReg <= '0;
        end else if (repairValid) begin
            histReg <= repairHist;
        end else if (specValid) begin
            histReg <= {specTaken, histReg[histWidth-1:1]};
        end
    end

    assign readEn = lookupValid && !stall;
    assign clearEn = usefulClear && !stall;

    always_ff @(posedge Clk) begin
        if (reset) begin
            stage1Valid <= 1'b0;
        end else if (!stall) begin
            stage1Valid <= lookupValid && !flush;
        end
    end

    // tags ride along with the table read
    always_ff @(posedge Clk) begin
        if (readEn) begin
            lookupTagReg <= lookupAddr.tag;
        end
    end

    tableIndexer lookupIndexer (.pc(lookupPc), .hist(histReg), .addr(lookupAddr));
    tableIndexer updIndexer (.pc(upd.pc), .hist(upd.hist), .addr(updAddr));

    always_comb begin
        for (int k = 0; k <= numTagged; k++) begin
            tableWe[k] = updValid && !stall && (upd.tableNum == k);
        end
    end

    predTable #(.entryT(baseEntry_t), .depth(1 << baseIdxWidth)) baseTable (
        .Clk(Clk), .reset(reset),
        .readEn(readEn), .readIdx(lookupAddr.baseIdx),
        .readEntry(baseRd), .readHit(baseHit),
        .writeEn(tableWe[0]), .writeIdx(updAddr.baseIdx),
        .writeEntry(baseEntry_t'{ctr: upd.ctr})
    );

    predTable #(.entryT(entry7_t), .depth(1 << tagIdxWidth[0])) t1Table (
        .Clk(Clk), .reset(reset),
        .readEn(readEn), .readIdx(lookupAddr.tagIdx[0][tagIdxWidth[0]-1:0]),
        .readEntry(t1Rd), .readHit(t1Hit),
        .writeEn(tableWe[1]), .writeIdx(updAddr.tagIdx[0][tagIdxWidth[0]-1:0]),
        .writeEntry(entry7_t'{tag: updAddr.tag[0][tagWidth[0]-1:0], ctr: upd.ctr})
    );

    predTable #(.entryT(entry7_t), .depth(1 << tagIdxWidth[1])) t2Table (
        .Clk(Clk), .reset(reset),
        .readEn(readEn), .readIdx(lookupAddr.tagIdx[1][tagIdxWidth[1]-1:0]),
        .readEntry(t2Rd), .readHit(t2Hit),
        .writeEn(tableWe[2]), .writeIdx(updAddr.tagIdx[1][tagIdxWidth[1]-1:0]),
        .writeEntry(entry7_t'{tag: updAddr.tag[1][tagWidth[1]-1:0], ctr: upd.ctr})
    );

    predTable #(.entryT(entry8_t), .depth(1 << tagIdxWidth[2])) t3Table (
        .Clk(Clk), .reset(reset),
        .readEn(readEn), .readIdx(lookupAddr.tagIdx[2][tagIdxWidth[2]-1:0]),
        .readEntry(t3Rd), .readHit(t3Hit),
        .writeEn(tableWe[3]), .writeIdx(updAddr.tagIdx[2][tagIdxWidth[2]-1:0]),
        .writeEntry(entry8_t'{tag: updAddr.tag[2][tagWidth[2]-1:0], ctr: upd.ctr})
    );

    predTable #(.entryT(entry8_t), .depth(1 << tagIdxWidth[3])) t4Table (
        .Clk(Clk), .reset(reset),
        .readEn(readEn), .readIdx(lookupAddr.tagIdx[3][tagIdxWidth[3]-1:0]),
        .readEntry(t4Rd), .readHit(t4Hit),
        .writeEn(tableWe[4]), .writeIdx(updAddr.tagIdx[3][tagIdxWidth[3]-1:0]),
        .writeEntry(entry8_t'{tag: updAddr.tag[3][tagWidth[3]-1:0], ctr: upd.ctr})
    );

    // useful counters share the tagged table's index
    for (genvar i = 0; i < numTagged; i++) begin : gUseful
        usefulTable #(.depth(1 << tagIdxWidth[i])) usefulBank (
            .Clk(Clk), .reset(reset), .clear(clearEn),
            .readEn(readEn), .readIdx(lookupAddr.tagIdx[i][tagIdxWidth[i]-1:0]),
            .readUseful(usefulRd[i]),
            .writeEn(tableWe[i+1]), .writeIdx(updAddr.tagIdx[i][tagIdxWidth[i]-1:0]),
            .writeUseful(upd.useful)
        );
    end

    predictSelect selectStage (
        .Clk(Clk), .reset(reset), .stall(stall), .flush(flush),
        .validIn(stage1Valid), .lookupTag(lookupTagReg),
        .baseEntry(baseRd), .baseHit(baseHit),
        .t1Entry(t1Rd), .t2Entry(t2Rd), .t3Entry(t3Rd), .t4Entry(t4Rd),
        .t1Hit(t1Hit), .t2Hit(t2Hit), .t3Hit(t3Hit), .t4Hit(t4Hit),
        .usefulIn(usefulRd),
        .predValid(predValid), .pred(pred)
    );

endmodule

// File: design/predictSelect.sv
module predictSelect (
    input logic Clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic validIn,
    input logic [tageGeomPkg::numTagged-1:0][tageGeomPkg::maxTagWidth-1:0] lookupTag,
    input tageTypesPkg::baseEntry_t baseEntry,
    input logic baseHit,
    input tageTypesPkg::entry7_t t1Entry,
    input tageTypesPkg::entry7_t t2Entry,
    input tageTypesPkg::entry8_t t3Entry,
    input tageTypesPkg::entry8_t t4Entry,
    input logic t1Hit,
    input logic t2Hit,
    input logic t3Hit,
    input logic t4Hit,
    input tageTypesPkg::ctr_t [tageGeomPkg::numTagged-1:0] usefulIn,
    output logic predValid,
    output tageTypesPkg::prediction_t pred
);

    import tageGeomPkg::*;
    import tageTypesPkg::*;

    logic [numTagged-1:0] tagHit;
    ctr_t [numTagged-1:0] tagCtr;
    prediction_t nextPred;

    // valid entry plus matching tag
    assign tagHit = {
        t4Hit && (t4Entry.tag == lookupTag[3][tagWidth[3]-1:0]),
        t3Hit && (t3Entry.tag == lookupTag[2][tagWidth[2]-1:0]),
        t2Hit && (t2Entry.tag == lookupTag[1][tagWidth[1]-1:0]),
        t1Hit && (t1Entry.tag == lookupTag[0][tagWidth[0]-1:0])
    };

    assign tagCtr = {t4Entry.ctr, t3Entry.ctr, t2Entry.ctr, t1Entry.ctr};

    // longest history hit wins, base table otherwise
    always_comb begin
        nextPred.provider = providerWidth'(providerBase);
        nextPred.ctr = baseHit ? baseEntry.ctr : ctrWidth'(baseInitCtr);
        for (int i = 0; i < numTagged; i++) begin
            if (tagHit[i]) begin
                nextPred.provider = providerWidth'(i + 1);
                nextPred.ctr = tagCtr[i];
            end
        end
        nextPred.taken = nextPred.ctr > takenThreshold;
        nextPred.useful = usefulIn;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            predValid <= 1'b0;
        end else if (!stall) begin
            predValid <= validIn && !flush;
        end
    end

    // held while stalled
    always_ff @(posedge Clk) begin
        if (!stall) begin
            pred <= nextPred;
        end
    end

endmodule

// File: design/usefulTable.sv
module usefulTable #(
    parameter int depth = 128
) (
    input logic Clk,
    input logic reset,
    input logic clear,
    input logic readEn,
    input logic [$clog2(depth)-1:0] readIdx,
    output tageTypesPkg::ctr_t readUseful,
    input logic writeEn,
    input logic [$clog2(depth)-1:0] writeIdx,
    input tageTypesPkg::ctr_t writeUseful
);

    import tageTypesPkg::*;

    ctr_t useful [depth];

    // global clear beats a single-entry write
    always_ff @(posedge Clk) begin
        if (reset || clear) begin
            useful <= '{default: '0};
        end else if (writeEn) begin
            useful[writeIdx] <= writeUseful;
        end
    end

    always_ff @(posedge Clk) begin
        if (readEn) begin
            readUseful <= useful[readIdx];
        end
    end

endmodule

// File: design/predTable.sv
module predTable #(
    parameter type entryT = logic,
    parameter int depth = 128
) (
    input logic Clk,
    input logic reset,
    input logic readEn,
    input logic [$clog2(depth)-1:0] readIdx,
    output entryT readEntry,
    output logic readHit,
    input logic writeEn,
    input logic [$clog2(depth)-1:0] writeIdx,
    input entryT writeEntry
);

    entryT mem [depth];
    logic [depth-1:0] valid;

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            mem[writeIdx] <= writeEntry;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            valid <= '0;
        end else if (writeEn) begin
            valid[writeIdx] <= 1'b1;
        end
    end

    // sync read returns old data on a same-edge write
    always_ff @(posedge Clk) begin
        if (readEn) begin
            readEntry <= mem[readIdx];
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            readHit <= 1'b0;
        end else if (readEn) begin
            readHit <= valid[readIdx];
        end
    end

endmodule

// File: design/tableIndexer.sv
module tableIndexer (
    input tageTypesPkg::pc_t pc,
    input tageTypesPkg::hist_t hist,
    output tageTypesPkg::tableAddr_t addr
);

    import tageGeomPkg::*;

    localparam int narrowTag = tagWidth[0];
    localparam int wideTag = tagWidth[numTagged-1];

    logic [narrowTag-1:0] pcFoldNarrow;
    logic [wideTag-1:0] pcFoldWide;
    wire [numTagged-1:0][maxIdxWidth-1:0] idxVec;
    wire [numTagged-1:0][maxTagWidth-1:0] tagVec;

    // pc half of the tag depends only on the tag width
    foldHash #(.inWidth(pcWidth - pcTagLsb), .outWidth(narrowTag)) pcNarrow (
        .in(pc[pcWidth-1:pcTagLsb]),
        .out(pcFoldNarrow)
    );

    foldHash #(.inWidth(pcWidth - pcTagLsb), .outWidth(wideTag)) pcWide (
        .in(pc[pcWidth-1:pcTagLsb]),
        .out(pcFoldWide)
    );

    for (genvar i = 0; i < numTagged; i++) begin : gTable
        localparam int idxW = tagIdxWidth[i];
        localparam int tagW = tagWidth[i];
        localparam int len = histLen[i];

        logic [idxW-1:0] histIdx;
        logic [tagW-1:0] histTag;
        logic [tagW-1:0] pcTag;

        // newest len bits of history
        foldHash #(.inWidth(len), .outWidth(idxW)) idxFold (
            .in(hist[histWidth-1 -: len]),
            .out(histIdx)
        );

        foldHash #(.inWidth(len), .outWidth(tagW)) tagFold (
            .in(hist[histWidth-1 -: len]),
            .out(histTag)
        );

        if (tagW == narrowTag) begin : gNarrow
            assign pcTag = pcFoldNarrow;
        end else begin : gWide
            assign pcTag = pcFoldWide;
        end

        assign idxVec[i] = maxIdxWidth'(pc[pcIdxLsb +: idxW] ^ histIdx);
        assign tagVec[i] = maxTagWidth'(pcTag ^ histTag);
    end

    assign addr = '{
        baseIdx: pc[pcIdxLsb +: baseIdxWidth],
        tagIdx: idxVec,
        tag: tagVec
    };

endmodule

// File: design/foldHash.sv
module foldHash #(
    parameter int inWidth = 16,
    parameter int outWidth = 8
) (
    input logic [inWidth-1:0] in,
    output logic [outWidth-1:0] out
);

    localparam int numChunks = (inWidth + outWidth - 1) / outWidth;

    logic [numChunks*outWidth-1:0] padded;

    // last chunk zero-padded at the top
    assign padded = (numChunks * outWidth)'(in);

    always_comb begin
        out = '0;
        for (int c = 0; c < numChunks; c++) begin
            out ^= padded[c*outWidth +: outWidth];
        end
    end

endmodule

// File: design/tageTypesPkg.sv
package tageTypesPkg;

    import tageGeomPkg::*;

    typedef logic [pcWidth-1:0] pc_t;
    typedef logic [histWidth-1:0] hist_t;
    typedef logic [ctrWidth-1:0] ctr_t;

    typedef struct packed {
        ctr_t ctr;
    } baseEntry_t;

    // T1 and T2
    typedef struct packed {
        logic [tagWidth[0]-1:0] tag;
        ctr_t ctr;
    } entry7_t;

    // T3 and T4
    typedef struct packed {
        logic [tagWidth[2]-1:0] tag;
        ctr_t ctr;
    } entry8_t;

    // narrower tables only use the low bits of their slot
    typedef struct packed {
        logic [baseIdxWidth-1:0] baseIdx;
        logic [numTagged-1:0][maxIdxWidth-1:0] tagIdx;
        logic [numTagged-1:0][maxTagWidth-1:0] tag;
    } tableAddr_t;

    // tableNum 0 is the base table
    typedef struct packed {
        logic [providerWidth-1:0] tableNum;
        pc_t pc;
        hist_t hist;
        ctr_t ctr;
        ctr_t useful;
    } update_t;

    typedef struct packed {
        logic taken;
        ctr_t ctr;
        logic [providerWidth-1:0] provider;
        ctr_t [numTagged-1:0] useful;
    } prediction_t;

endpackage

// File: design/tageGeomPkg.sv
package tageGeomPkg;

    localparam int pcWidth = 32;
    // newest history bit is the msb
    localparam int histWidth = 16;
    localparam int numTagged = 4;

    // base table indexed straight from pc[11:5]
    localparam int baseIdxWidth = 7;
    localparam int pcIdxLsb = 5;
    localparam int pcTagLsb = 12;

    // per tagged table, T1 first
    localparam int tagIdxWidth [numTagged] = '{7, 7, 8, 8};
    localparam int tagWidth [numTagged] = '{7, 7, 8, 8};
    localparam int histLen [numTagged] = '{2, 4, 8, 16};

    // slot widths in the address struct
    localparam int maxIdxWidth = 8;
    localparam int maxTagWidth = 8;

    localparam int ctrWidth = 3;
    localparam int takenThreshold = 4;
    // weakly not taken
    localparam int baseInitCtr = 4;

    localparam int providerWidth = $clog2(numTagged + 1);
    localparam int providerBase = 0;

endpackage
